/* sources.f */
+incdir+verilog
verilog/mips_pkg.sv
verilog/mips_dbg_if.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/mips_regfile.sv
verilog/mips_core.sv
verilog/debug_unit.sv
verilog/mips_debug_top.sv
dv/tb_mips_debug.sv

/* Makefile */
TOOL     = verilator
TOP      = tb_mips_debug
FILELIST = sources.f
OBJ_DIR  = obj_dir
FLAGS    = --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
PASS_MSG = STATUS: PASS

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) -f $(FILELIST)

run: compile
	out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* dv/tb_mips_debug.sv */
`timescale 1ns/1ns
`default_nettype none
`include "mips_defs.svh"

module tb_mips_debug;

    localparam int MAX_LEN    = 12;
    localparam int RUN_ROUNDS = 2;
    localparam int NUM_CMDS   = 24;
    localparam int CMD_BYTES  = `REPORT_BYTES + 4;
    localparam int TIMEOUT    = NUM_CMDS * CMD_BYTES * 10 * `CLKS_PER_BIT + 20000;

    logic        mips_clk;
    logic        basys_reset;
    logic        uart_rx_line;
    wire         uart_tx_line;
    int          cycle_cnt = 0;

    // Instruction-set model state
    logic [31:0] m_imem [`IMEM_WORDS];
    logic [31:0] m_regs [32];
    logic [31:0] m_dmem [`DMEM_WORDS];
    logic [31:0] m_pc;
    logic [31:0] m_cycles;
    logic        m_halted;

    mips_debug_top dut_i (
        .i_mips_clk    (mips_clk),
        .i_basys_reset (basys_reset),
        .i_uart_rx     (uart_rx_line),
        .o_uart_tx     (uart_tx_line)
    );

    always #5 mips_clk = ~mips_clk;

    always @(posedge mips_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            $display("Timeout: serial transfer stuck after %0d cycles", cycle_cnt);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    //////////////////////////////
    // Serial line
    //////////////////////////////
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge mips_clk);
            uart_rx_line <= frame[i];
            repeat (`CLKS_PER_BIT - 1) @(posedge mips_clk);
        end
    endtask

    task automatic recv_byte(output logic [7:0] b);
        while (uart_tx_line !== 1'b0) begin
            @(negedge mips_clk);
        end
        // Middle of the start bit
        repeat (`CLKS_PER_BIT / 2) @(negedge mips_clk);
        check_value("o_uart_tx start bit", 32'd0, {31'd0, uart_tx_line});
        for (int i = 0; i < 8; i++) begin
            repeat (`CLKS_PER_BIT) @(negedge mips_clk);
            b[i] = uart_tx_line;
        end
        repeat (`CLKS_PER_BIT) @(negedge mips_clk);
        check_value("o_uart_tx stop bit", 32'd1, {31'd0, uart_tx_line});
    endtask

    task automatic recv_word(output logic [31:0] w);
        logic [7:0] b;
        for (int k = 0; k < 4; k++) begin
            recv_byte(b);
            w[8*k +: 8] = b;
        end
    endtask

    task automatic expect_idle(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge mips_clk);
            check_value("o_uart_tx", 32'd1, {31'd0, uart_tx_line});
        end
    endtask

    //////////////////////////////
    // Instruction-set model
    //////////////////////////////
    task automatic write_reg(input logic [4:0] idx, input logic [31:0] val);
        if (idx != 5'd0) begin
            m_regs[idx] = val;
        end
    endtask

    task automatic model_step();
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] next_pc;
        logic [3:0]  widx;
        if (!m_halted) begin
            ins      = m_imem[m_pc[7:2]];
            a        = m_regs[ins[25:21]];
            b        = m_regs[ins[20:16]];
            imm      = {{16{ins[15]}}, ins[15:0]};
            next_pc  = m_pc + 32'd4;
            widx     = 4'((a + imm) >> 2);
            m_cycles = m_cycles + 32'd1;
            case (ins[31:26])
                6'h00: begin
                    case (ins[5:0])
                        6'h21:   write_reg(ins[15:11], a + b);
                        6'h23:   write_reg(ins[15:11], a - b);
                        6'h24:   write_reg(ins[15:11], a & b);
                        6'h25:   write_reg(ins[15:11], a | b);
                        6'h2a:   write_reg(ins[15:11], {31'd0, $signed(a) < $signed(b)});
                        default: ;
                    endcase
                end
                6'h09: write_reg(ins[20:16], a + imm);
                6'h23: write_reg(ins[20:16], m_dmem[widx]);
                6'h2b: m_dmem[widx] = b;
                6'h04: begin
                    if (a == b) begin
                        next_pc = m_pc + 32'd4 + (imm << 2);
                    end
                end
                // Halt keeps the PC on the halt word
                6'h3f: begin
                    m_halted = 1'b1;
                    next_pc  = m_pc;
                end
                default: ;
            endcase
            m_pc = next_pc;
        end
    endtask

    task automatic model_run();
        while (!m_halted) begin
            model_step();
        end
    endtask

    task automatic gen_program(input int len);
        int         off;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [5:0] fn;
        for (int i = 0; i < len; i++) begin
            rs = 5'($urandom_range(15, 0));
            rt = 5'($urandom_range(15, 0));
            rd = 5'($urandom_range(15, 0));
            case ($urandom_range(5, 0))
                0, 1: begin
                    case ($urandom_range(4, 0))
                        0:       fn = 6'h21;
                        1:       fn = 6'h23;
                        2:       fn = 6'h24;
                        3:       fn = 6'h25;
                        default: fn = 6'h2a;
                    endcase
                    m_imem[i] = {6'h00, rs, rt, rd, 5'd0, fn};
                end
                2: m_imem[i] = {6'h09, rs, rt, 16'($urandom)};
                3: m_imem[i] = {6'h23, 5'd0, rt, 10'd0, 4'($urandom_range(15, 0)), 2'b00};
                4: m_imem[i] = {6'h2b, 5'd0, rt, 10'd0, 4'($urandom_range(15, 0)), 2'b00};
                default: begin
                    // Forward only, at most onto the halt word
                    off = int'($urandom_range(len - 1 - i, 0));
                    if ($urandom_range(1, 0) == 1) begin
                        rt = rs;
                    end
                    m_imem[i] = {6'h04, rs, rt, 16'(off)};
                end
            endcase
        end
        m_imem[len] = {6'h3f, 26'd0};
    endtask

    task automatic load_program(input int len);
        gen_program(len);
        m_pc     = 32'd0;
        m_cycles = 32'd0;
        m_halted = 1'b0;
        send_byte(8'h4C);
        send_byte(8'(len + 1));
        for (int i = 0; i <= len; i++) begin
            for (int k = 0; k < 4; k++) begin
                send_byte(m_imem[i][8*k +: 8]);
            end
        end
    endtask

    task automatic check_report();
        logic [31:0] w;
        recv_word(w);
        check_value("pc", m_pc, w);
        recv_word(w);
        check_value("cycles", m_cycles, w);
        for (int r = 0; r < 32; r++) begin
            recv_word(w);
            check_value($sformatf("r%0d", r), m_regs[r], w);
        end
        for (int m = 0; m < `DMEM_WORDS; m++) begin
            recv_word(w);
            check_value($sformatf("dmem[%0d]", m), m_dmem[m], w);
        end
    endtask

    task automatic command_report(input logic [7:0] cmd);
        fork
            send_byte(cmd);
            check_report();
        join
    endtask

    task automatic send_junk();
        logic [7:0] b;
        b = 8'($urandom);
        while (b == 8'h4C || b == 8'h52 || b == 8'h53) begin
            b = 8'($urandom);
        end
        fork
            send_byte(b);
            expect_idle(12 * `CLKS_PER_BIT);
        join
    endtask

    initial begin
        int len;
        int extra;
        mips_clk     = 1'b0;
        basys_reset  <= 1'b1;
        uart_rx_line <= 1'b1;
        void'($urandom(32'h0add5cde));
        for (int i = 0; i < `IMEM_WORDS; i++) begin
            m_imem[i] = 32'd0;
        end
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = 32'd0;
        end
        for (int i = 0; i < `DMEM_WORDS; i++) begin
            m_dmem[i] = 32'd0;
        end
        repeat (5) @(posedge mips_clk);
        basys_reset <= 1'b0;
        expect_idle(100);

        for (int round = 0; round < RUN_ROUNDS; round++) begin
            len = int'($urandom_range(MAX_LEN, 4));
            load_program(len);
            send_junk();
            model_run();
            command_report(8'h52);
            // Already halted, so nothing runs
            send_junk();
            model_run();
            command_report(8'h52);
        end

        // Single steps, then two more past the halt
        len = int'($urandom_range(MAX_LEN, 4));
        load_program(len);
        extra = 0;
        while (extra < 2) begin
            if (m_halted) begin
                extra++;
            end
            model_step();
            command_report(8'h53);
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/mips_debug_top.sv */
`timescale 1ns/1ns
`default_nettype none

module mips_debug_top (
    input  wire i_mips_clk,
    input  wire i_basys_reset,
    input  wire i_uart_rx,
    output wire o_uart_tx
);
    import mips_pkg::*;

    logic  rx_valid;
    byte_t rx_data;
    logic  tx_start;
    byte_t tx_data;
    logic  tx_busy;

    mips_dbg_if dbg_if ();

    uart_rx uart_rx_i (
        .i_mips_clk    (i_mips_clk),
        .i_basys_reset (i_basys_reset),
        .i_rx          (i_uart_rx),
        .o_valid       (rx_valid),
        .o_data        (rx_data)
    );

    uart_tx uart_tx_i (
        .i_mips_clk    (i_mips_clk),
        .i_basys_reset (i_basys_reset),
        .i_start       (tx_start),
        .i_data        (tx_data),
        .o_tx          (o_uart_tx),
        .o_busy        (tx_busy)
    );

    debug_unit debug_unit_i (
        .i_mips_clk    (i_mips_clk),
        .i_basys_reset (i_basys_reset),
        .i_rx_valid    (rx_valid),
        .i_rx_data     (rx_data),
        .i_tx_busy     (tx_busy),
        .o_tx_start    (tx_start),
        .o_tx_data     (tx_data),
        .dbg           (dbg_if.dbg)
    );

    mips_core mips_core_i (
        .i_mips_clk    (i_mips_clk),
        .i_basys_reset (i_basys_reset),
        .dbg           (dbg_if.core)
    );

endmodule

`default_nettype wire

/* verilog/debug_unit.sv */
`timescale 1ns/1ns
`default_nettype none
`include "mips_defs.svh"

module debug_unit (
    input  wire                  i_mips_clk,
    input  wire                  i_basys_reset,
    input  wire                  i_rx_valid,
    input  wire mips_pkg::byte_t i_rx_data,
    input  wire                  i_tx_busy,
    output logic                 o_tx_start,
    output mips_pkg::byte_t      o_tx_data,
    mips_dbg_if.dbg              dbg
);
    import mips_pkg::*;

    localparam int    CNT_W    = $clog2(`IMEM_WORDS) + 1;
    localparam byte_t CMD_LOAD = 8'h4C;
    localparam byte_t CMD_RUN  = 8'h52;
    localparam byte_t CMD_STEP = 8'h53;

    dbg_state_t       state_q;
    logic [CNT_W-1:0] word_cnt_q;
    imem_addr_t       word_idx_q;
    logic [1:0]       byte_sel_q;
    word_t            word_buf_q;
    logic [7:0]       rpt_idx_q;
    logic [5:0]       rpt_word;
    word_t            rpt_data;
    logic             rpt_last;
    logic             last_word;

    assign last_word = (({1'b0, word_idx_q} + 1'b1) == word_cnt_q);
    assign rpt_last  = (rpt_idx_q == 8'(`REPORT_BYTES - 1));

    always_ff @(posedge i_mips_clk or posedge i_basys_reset) begin
        if (i_basys_reset) begin
            state_q        <= DBG_IDLE;
            word_cnt_q     <= '0;
            word_idx_q     <= '0;
            byte_sel_q     <= '0;
            rpt_idx_q      <= '0;
            dbg.imem_wr    <= 1'b0;
            dbg.core_clear <= 1'b0;
        end else begin
            dbg.imem_wr    <= 1'b0;
            dbg.core_clear <= 1'b0;
            // Advance past the word just written
            if (dbg.imem_wr) begin
                word_idx_q <= word_idx_q + 1'b1;
            end
            case (state_q)
                DBG_IDLE: begin
                    if (i_rx_valid) begin
                        case (i_rx_data)
                            CMD_LOAD: state_q <= DBG_LOAD_CNT;
                            CMD_RUN:  state_q <= DBG_RUN;
                            CMD_STEP: state_q <= DBG_STEP;
                            default:  state_q <= DBG_IDLE;
                        endcase
                    end
                end
                DBG_LOAD_CNT: begin
                    if (i_rx_valid) begin
                        word_cnt_q <= i_rx_data[CNT_W-1:0];
                        word_idx_q <= '0;
                        byte_sel_q <= '0;
                        if (i_rx_data == '0 || i_rx_data > 8'(`IMEM_WORDS)) begin
                            state_q <= DBG_IDLE;
                        end else begin
                            state_q <= DBG_LOAD_WORD;
                        end
                    end
                end
                DBG_LOAD_WORD: begin
                    if (i_rx_valid) begin
                        byte_sel_q <= byte_sel_q + 1'b1;
                        if (byte_sel_q == 2'd3) begin
                            dbg.imem_wr    <= 1'b1;
                            dbg.core_clear <= 1'b1;
                            if (last_word) begin
                                state_q <= DBG_IDLE;
                            end
                        end
                    end
                end
                DBG_RUN: begin
                    if (dbg.halted) begin
                        rpt_idx_q <= '0;
                        state_q   <= DBG_REPORT;
                    end
                end
                DBG_STEP: begin
                    rpt_idx_q <= '0;
                    state_q   <= DBG_REPORT;
                end
                DBG_REPORT: state_q <= DBG_TX_WAIT;
                DBG_TX_WAIT: begin
                    if (!i_tx_busy) begin
                        if (rpt_last) begin
                            state_q <= DBG_IDLE;
                        end else begin
                            rpt_idx_q <= rpt_idx_q + 1'b1;
                            state_q   <= DBG_REPORT;
                        end
                    end
                end
                default: state_q <= DBG_IDLE;
            endcase
        end
    end

    // Words arrive LSB first
    always_ff @(posedge i_mips_clk) begin
        if (state_q == DBG_LOAD_WORD && i_rx_valid) begin
            word_buf_q <= {i_rx_data, word_buf_q[31:8]};
        end
    end

    assign dbg.imem_addr = word_idx_q;
    assign dbg.imem_data = word_buf_q;
    assign dbg.exec_en   = (state_q == DBG_RUN || state_q == DBG_STEP) && !dbg.halted;

    //////////////////////////////
    // Report byte select
    //////////////////////////////
    // Word 0 PC, 1 count, 2..33 registers, 34..49 memory
    assign rpt_word    = rpt_idx_q[7:2];
    assign dbg.reg_sel = reg_idx_t'(rpt_word - 6'd2);
    assign dbg.mem_sel = dmem_addr_t'(rpt_word - 6'd34);

    always_comb begin
        if (rpt_word == 6'd0) begin
            rpt_data = dbg.pc;
        end else if (rpt_word == 6'd1) begin
            rpt_data = dbg.cycles;
        end else if (rpt_word < 6'd34) begin
            rpt_data = dbg.reg_data;
        end else begin
            rpt_data = dbg.mem_data;
        end
    end

    assign o_tx_data  = rpt_data[8*rpt_idx_q[1:0] +: 8];
    assign o_tx_start = (state_q == DBG_REPORT);

    // Each report byte goes to an idle transmitter that takes it
    assert property (@(posedge i_mips_clk) disable iff (i_basys_reset)
        o_tx_start |-> !i_tx_busy ##1 i_tx_busy);

endmodule

`default_nettype wire

/* verilog/mips_core.sv */
`timescale 1ns/1ns
`default_nettype none
`include "mips_defs.svh"

module mips_core (
    input  wire     i_mips_clk,
    input  wire     i_basys_reset,
    mips_dbg_if.core dbg
);
    import mips_pkg::*;

    localparam opcode_t OP_RTYPE = 6'b000000;
    localparam opcode_t OP_BEQ   = 6'b000100;
    localparam opcode_t OP_ADDIU = 6'b001001;
    localparam opcode_t OP_LW    = 6'b100011;
    localparam opcode_t OP_SW    = 6'b101011;
    localparam opcode_t OP_HALT  = 6'b111111;
    localparam funct_t  FN_ADDU  = 6'b100001;
    localparam funct_t  FN_SUBU  = 6'b100011;
    localparam funct_t  FN_AND   = 6'b100100;
    localparam funct_t  FN_OR    = 6'b100101;
    localparam funct_t  FN_SLT   = 6'b101010;

    word_t      imem [`IMEM_WORDS];
    word_t      dmem [`DMEM_WORDS];
    word_t      pc_q;
    word_t      cycles_q;
    logic       halted_q;
    word_t      instr;
    word_t      pc_plus4;
    word_t      imm_ext;
    word_t      rs_val;
    word_t      rt_val;
    word_t      alu_y;
    word_t      wb_data;
    opcode_t    opcode;
    funct_t     funct;
    reg_idx_t   wb_idx;
    imem_addr_t fetch_idx;
    dmem_addr_t dmem_idx;
    logic       wb_en;
    logic       retire;

    //////////////////////////////
    // Fetch and decode
    //////////////////////////////
    assign fetch_idx = pc_q[7:2];
    assign instr     = imem[fetch_idx];
    assign opcode    = instr[31:26];
    assign funct     = instr[5:0];
    assign imm_ext   = {{16{instr[15]}}, instr[15:0]};
    assign pc_plus4  = pc_q + 32'd4;
    assign retire    = dbg.exec_en && !halted_q;

    mips_regfile regfile_i (
        .i_mips_clk    (i_mips_clk),
        .i_basys_reset (i_basys_reset),
        .i_we          (retire && wb_en),
        .i_waddr       (wb_idx),
        .i_wdata       (wb_data),
        .i_raddr_a     (instr[25:21]),
        .i_raddr_b     (instr[20:16]),
        .i_dbg_sel     (dbg.reg_sel),
        .o_rdata_a     (rs_val),
        .o_rdata_b     (rt_val),
        .o_dbg_data    (dbg.reg_data)
    );

    // ALU, also the lw/sw address
    always_comb begin
        alu_y = rs_val + imm_ext;
        if (opcode == OP_RTYPE) begin
            case (funct)
                FN_SUBU: alu_y = rs_val - rt_val;
                FN_AND:  alu_y = rs_val & rt_val;
                FN_OR:   alu_y = rs_val | rt_val;
                FN_SLT:  alu_y = {31'd0, $signed(rs_val) < $signed(rt_val)};
                default: alu_y = rs_val + rt_val;
            endcase
        end
    end

    assign dmem_idx = alu_y[5:2];

    always_comb begin
        wb_en   = 1'b0;
        wb_idx  = instr[20:16];
        wb_data = alu_y;
        case (opcode)
            OP_RTYPE: begin
                wb_en  = funct inside {FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_SLT};
                wb_idx = instr[15:11];
            end
            OP_ADDIU: wb_en = 1'b1;
            OP_LW: begin
                wb_en   = 1'b1;
                wb_data = dmem[dmem_idx];
            end
            default: wb_en = 1'b0;
        endcase
    end

    //////////////////////////////
    // PC, halt and cycle count
    //////////////////////////////
    always_ff @(posedge i_mips_clk or posedge i_basys_reset) begin
        if (i_basys_reset) begin
            pc_q     <= '0;
            cycles_q <= '0;
            halted_q <= 1'b0;
        end else if (dbg.core_clear) begin
            pc_q     <= '0;
            cycles_q <= '0;
            halted_q <= 1'b0;
        end else begin
            if (dbg.exec_en) begin
                cycles_q <= cycles_q + 1'b1;
            end
            if (retire) begin
                if (opcode == OP_HALT) begin
                    halted_q <= 1'b1;
                end else if (opcode == OP_BEQ && rs_val == rt_val) begin
                    pc_q <= pc_plus4 + {imm_ext[29:0], 2'b00};
                end else begin
                    pc_q <= pc_plus4;
                end
            end
        end
    end

    always_ff @(posedge i_mips_clk or posedge i_basys_reset) begin
        if (i_basys_reset) begin
            for (int i = 0; i < `IMEM_WORDS; i++) begin
                imem[i] <= '0;
            end
        end else if (dbg.imem_wr) begin
            imem[dbg.imem_addr] <= dbg.imem_data;
        end
    end

    always_ff @(posedge i_mips_clk or posedge i_basys_reset) begin
        if (i_basys_reset) begin
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (retire && opcode == OP_SW) begin
            dmem[dmem_idx] <= rt_val;
        end
    end

    assign dbg.halted   = halted_q;
    assign dbg.pc       = pc_q;
    assign dbg.cycles   = cycles_q;
    assign dbg.mem_data = dmem[dbg.mem_sel];

    // Halted core holds its state until cleared
    assert property (@(posedge i_mips_clk) disable iff (i_basys_reset)
        (halted_q && !dbg.core_clear) |=> ($stable(pc_q) && $stable(cycles_q)));

endmodule

`default_nettype wire

/* verilog/mips_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module mips_regfile (
    input  wire                     i_mips_clk,
    input  wire                     i_basys_reset,
    input  wire                     i_we,
    input  wire mips_pkg::reg_idx_t i_waddr,
    input  wire mips_pkg::word_t    i_wdata,
    input  wire mips_pkg::reg_idx_t i_raddr_a,
    input  wire mips_pkg::reg_idx_t i_raddr_b,
    input  wire mips_pkg::reg_idx_t i_dbg_sel,
    output mips_pkg::word_t         o_rdata_a,
    output mips_pkg::word_t         o_rdata_b,
    output mips_pkg::word_t         o_dbg_data
);
    import mips_pkg::*;

    word_t regs_q [32];

    // r0 is cleared by reset and never written
    always_ff @(posedge i_mips_clk or posedge i_basys_reset) begin
        if (i_basys_reset) begin
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (i_we && i_waddr != '0) begin
            regs_q[i_waddr] <= i_wdata;
        end
    end

    assign o_rdata_a  = regs_q[i_raddr_a];
    assign o_rdata_b  = regs_q[i_raddr_b];
    assign o_dbg_data = regs_q[i_dbg_sel];

    assert property (@(posedge i_mips_clk) disable iff (i_basys_reset)
        (i_raddr_a == '0) |-> (o_rdata_a == '0));

endmodule

`default_nettype wire

/* verilog/uart_tx.sv */
`timescale 1ns/1ns
`default_nettype none
`include "mips_defs.svh"

module uart_tx (
    input  wire                  i_mips_clk,
    input  wire                  i_basys_reset,
    input  wire                  i_start,
    input  wire mips_pkg::byte_t i_data,
    output logic                 o_tx,
    output logic                 o_busy
);

    localparam int CNT_W = $clog2(`CLKS_PER_BIT);

    logic [9:0]       frame_q;
    logic [3:0]       bit_cnt_q;
    logic [CNT_W-1:0] clk_cnt_q;

    // Ones shift in behind the frame, so the line rests high
    assign o_tx = frame_q[0];

    always_ff @(posedge i_mips_clk or posedge i_basys_reset) begin
        if (i_basys_reset) begin
            frame_q   <= '1;
            bit_cnt_q <= '0;
            clk_cnt_q <= '0;
            o_busy    <= 1'b0;
        end else if (!o_busy) begin
            if (i_start) begin
                frame_q   <= {1'b1, i_data, 1'b0};
                bit_cnt_q <= '0;
                clk_cnt_q <= '0;
                o_busy    <= 1'b1;
            end
        end else if (clk_cnt_q == CNT_W'(`CLKS_PER_BIT - 1)) begin
            clk_cnt_q <= '0;
            frame_q   <= {1'b1, frame_q[9:1]};
            if (bit_cnt_q == 4'd9) begin
                o_busy <= 1'b0;
            end else begin
                bit_cnt_q <= bit_cnt_q + 1'b1;
            end
        end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
        end
    end

    assert property (@(posedge i_mips_clk) disable iff (i_basys_reset)
        i_start |-> !o_busy);

endmodule

`default_nettype wire

/* verilog/uart_rx.sv */
`timescale 1ns/1ns
`default_nettype none
`include "mips_defs.svh"

module uart_rx (
    input  wire             i_mips_clk,
    input  wire             i_basys_reset,
    input  wire             i_rx,
    output logic            o_valid,
    output mips_pkg::byte_t o_data
);
    import mips_pkg::*;

    localparam int CNT_W = $clog2(`CLKS_PER_BIT);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t        state_q;
    logic [CNT_W-1:0] clk_cnt_q;
    logic [2:0]       bit_idx_q;
    logic             rx_meta_q;
    logic             rx_sync_q;
    byte_t            shift_q;
    logic             bit_done;
    logic             half_done;

    assign bit_done  = (clk_cnt_q == CNT_W'(`CLKS_PER_BIT - 1));
    assign half_done = (clk_cnt_q == CNT_W'(`CLKS_PER_BIT / 2 - 1));
    assign o_data    = shift_q;

    always_ff @(posedge i_mips_clk or posedge i_basys_reset) begin
        if (i_basys_reset) begin
            rx_meta_q <= 1'b1;
            rx_sync_q <= 1'b1;
            state_q   <= RX_IDLE;
            clk_cnt_q <= '0;
            bit_idx_q <= '0;
            o_valid   <= 1'b0;
        end else begin
            rx_meta_q <= i_rx;
            rx_sync_q <= rx_meta_q;
            o_valid   <= 1'b0;
            clk_cnt_q <= clk_cnt_q + 1'b1;
            case (state_q)
                RX_IDLE: begin
                    clk_cnt_q <= '0;
                    if (!rx_sync_q) begin
                        state_q <= RX_START;
                    end
                end
                RX_START: begin
                    // Start bit gone by mid-bit means a glitch
                    if (half_done) begin
                        clk_cnt_q <= '0;
                        bit_idx_q <= '0;
                        state_q   <= rx_sync_q ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (bit_done) begin
                        clk_cnt_q <= '0;
                        bit_idx_q <= bit_idx_q + 1'b1;
                        if (bit_idx_q == 3'd7) begin
                            state_q <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (bit_done) begin
                        o_valid <= rx_sync_q;
                        state_q <= RX_IDLE;
                    end
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

    // LSB first
    always_ff @(posedge i_mips_clk) begin
        if (state_q == RX_DATA && bit_done) begin
            shift_q <= {rx_sync_q, shift_q[7:1]};
        end
    end

    assert property (@(posedge i_mips_clk) disable iff (i_basys_reset)
        o_valid |=> !o_valid);

endmodule

`default_nettype wire

/* verilog/mips_dbg_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface mips_dbg_if;
    import mips_pkg::*;

    // Debug unit to core
    logic       exec_en;
    logic       core_clear;
    logic       imem_wr;
    imem_addr_t imem_addr;
    word_t      imem_data;
    reg_idx_t   reg_sel;
    dmem_addr_t mem_sel;

    // Core to debug unit
    logic       halted;
    word_t      pc;
    word_t      cycles;
    word_t      reg_data;
    word_t      mem_data;

    modport dbg (
        output exec_en, core_clear, imem_wr, imem_addr, imem_data, reg_sel, mem_sel,
        input  halted, pc, cycles, reg_data, mem_data
    );

    modport core (
        input  exec_en, core_clear, imem_wr, imem_addr, imem_data, reg_sel, mem_sel,
        output halted, pc, cycles, reg_data, mem_data
    );

endinterface

`default_nettype wire

/* verilog/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [5:0]  imem_addr_t;
    typedef logic [3:0]  dmem_addr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [7:0]  byte_t;

    // Debug command FSM
    typedef enum logic [2:0] {
        DBG_IDLE,
        DBG_LOAD_CNT,
        DBG_LOAD_WORD,
        DBG_RUN,
        DBG_STEP,
        DBG_REPORT,
        DBG_TX_WAIT
    } dbg_state_t;

endpackage

`default_nettype wire

/* verilog/mips_defs.svh */
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// Serial bit time in mips_clk cycles
`define CLKS_PER_BIT 16

// Memory depths in 32-bit words
`define IMEM_WORDS 64
`define DMEM_WORDS 16

// PC, cycle count, 32 registers and 16 memory words
`define REPORT_BYTES 200

`endif
